//--- include/menu_settings.svh
`ifndef MENU_SETTINGS_SVH
`define MENU_SETTINGS_SVH

// position and counter width
`define COORD_W 12

// 800x600 at 40 MHz, both syncs active high
`define H_ACTIVE 12'd800
`define H_FRONT  12'd40
`define H_SYNC   12'd128
`define H_TOTAL  12'd1056

`define V_ACTIVE 12'd600
`define V_FRONT  12'd1
`define V_SYNC   12'd4
`define V_TOTAL  12'd628

// both buttons share the x range
`define BUTTON_X  12'd300
`define BUTTON_W  12'd200
`define BUTTON_H  12'd60
`define BUTTON_Y1 12'd200
`define BUTTON_Y2 12'd340

`define CURSOR_SIZE 12'd8

`define COLOR_START  12'h036
`define COLOR_GAME   12'h161
`define COLOR_END    12'h511
`define COLOR_BUTTON 12'hcc8
`define COLOR_CURSOR 12'hfff

`endif

//--- logic/menuPkg.sv
`include "menu_settings.svh"

package menuPkg;

    // one-hot screen codes
    typedef enum logic [3:0] {
        startScreen = 4'b0001,
        gameScreen  = 4'b0010,
        endScreen   = 4'b0100
    } screenT;

    // 4 bits per channel, r in the top nibble
    typedef logic [11:0] rgbT;

    // inclusive box test, end point computed one bit wider
    function automatic logic inRect(
        input logic [`COORD_W-1:0] x,
        input logic [`COORD_W-1:0] y,
        input logic [`COORD_W-1:0] x0,
        input logic [`COORD_W-1:0] y0,
        input logic [`COORD_W-1:0] w,
        input logic [`COORD_W-1:0] h
    );
        logic [`COORD_W:0] xEnd;
        logic [`COORD_W:0] yEnd;
        xEnd = {1'b0, x0} + {1'b0, w};
        yEnd = {1'b0, y0} + {1'b0, h};
        return (x >= x0) && ({1'b0, x} <= xEnd) &&
               (y >= y0) && ({1'b0, y} <= yEnd);
    endfunction

endpackage

//--- logic/vgaBus.sv
`timescale 1ns/1ns

`include "menu_settings.svh"

// one pixel in flight between the video stages
interface vgaBus;
    import menuPkg::*;

    logic [`COORD_W-1:0] hcount;
    logic [`COORD_W-1:0] vcount;
    logic                hsync;
    logic                vsync;
    logic                blank;
    rgbT                 rgb;

    modport src (
        output hcount, vcount, hsync, vsync, blank, rgb
    );

    modport sink (
        input hcount, vcount, hsync, vsync, blank, rgb
    );

endinterface

//--- logic/vgaTiming.sv
`timescale 1ns/1ns

`include "menu_settings.svh"

module vgaTiming (
    input logic clk,
    input logic rst,
    vgaBus.src  timingOut
);

    logic [`COORD_W-1:0] hNext;
    logic [`COORD_W-1:0] vNext;

    ////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////

    always_comb begin
        hNext = timingOut.hcount + 12'd1;
        vNext = timingOut.vcount;
        if (timingOut.hcount == `H_TOTAL - 12'd1) begin
            hNext = '0;
            if (timingOut.vcount == `V_TOTAL - 12'd1) begin
                vNext = '0;
            end else begin
                vNext = timingOut.vcount + 12'd1;
            end
        end
    end

    // sync and blank decoded from the next count so they line up with it
    always_ff @(posedge clk) begin
        if (rst) begin
            timingOut.hcount <= '0;
            timingOut.vcount <= '0;
            timingOut.hsync  <= 1'b0;
            timingOut.vsync  <= 1'b0;
            timingOut.blank  <= 1'b0;
        end else begin
            timingOut.hcount <= hNext;
            timingOut.vcount <= vNext;
            timingOut.hsync  <= (hNext >= `H_ACTIVE + `H_FRONT) &&
                                (hNext <  `H_ACTIVE + `H_FRONT + `H_SYNC);
            timingOut.vsync  <= (vNext >= `V_ACTIVE + `V_FRONT) &&
                                (vNext <  `V_ACTIVE + `V_FRONT + `V_SYNC);
            timingOut.blank  <= (hNext >= `H_ACTIVE) || (vNext >= `V_ACTIVE);
        end
    end

    // no colour at this stage
    assign timingOut.rgb = '0;

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    countersInRange: assert property (
        @(posedge clk) disable iff (rst)
        (timingOut.hcount < `H_TOTAL) && (timingOut.vcount < `V_TOTAL)
    ) else $error("vga counter out of range h=%0d v=%0d",
                  timingOut.hcount, timingOut.vcount);

endmodule

//--- logic/screenFsm.sv
`timescale 1ns/1ns

`include "menu_settings.svh"

module screenFsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                mouseLeft,
    input  logic                mouseRight,
    input  logic [`COORD_W-1:0] xpos,
    input  logic [`COORD_W-1:0] ypos,
    output menuPkg::screenT     screen
);

    import menuPkg::*;

    screenT state;
    screenT stateNext;
    logic   hitOne;
    logic   hitTwo;

    // button hits at the mouse position
    assign hitOne = inRect(xpos, ypos, `BUTTON_X, `BUTTON_Y1, `BUTTON_W, `BUTTON_H);
    assign hitTwo = inRect(xpos, ypos, `BUTTON_X, `BUTTON_Y2, `BUTTON_W, `BUTTON_H);

    ////////////////////////////////////////////////////////////
    // screen transitions
    ////////////////////////////////////////////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            startScreen: begin
                if (mouseLeft && (hitOne || hitTwo)) begin
                    stateNext = gameScreen;
                end
            end
            gameScreen: begin
                if (mouseRight) begin
                    stateNext = endScreen;
                end
            end
            endScreen: begin
                // button one back to the menu, button two replays
                if (mouseLeft && hitOne) begin
                    stateNext = startScreen;
                end else if (mouseLeft && hitTwo) begin
                    stateNext = gameScreen;
                end
            end
            default: begin
                stateNext = startScreen;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= startScreen;
        end else begin
            state <= stateNext;
        end
    end

    assign screen = state;

    legalScreen: assert property (
        @(posedge clk) disable iff (rst)
        screen inside {startScreen, gameScreen, endScreen}
    ) else $error("illegal screen code %b", screen);

endmodule

//--- logic/menuRenderer.sv
`timescale 1ns/1ns

`include "menu_settings.svh"

module menuRenderer (
    input logic            clk,
    input logic            rst,
    input menuPkg::screenT screen,
    vgaBus.sink            timingIn,
    vgaBus.src             paintOut
);

    import menuPkg::*;

    logic onButton;
    rgbT  background;
    rgbT  pixel;

    ////////////////////////////////////////////////////////////
    // colour select
    ////////////////////////////////////////////////////////////

    assign onButton =
        inRect(timingIn.hcount, timingIn.vcount,
               `BUTTON_X, `BUTTON_Y1, `BUTTON_W, `BUTTON_H) ||
        inRect(timingIn.hcount, timingIn.vcount,
               `BUTTON_X, `BUTTON_Y2, `BUTTON_W, `BUTTON_H);

    always_comb begin
        case (screen)
            startScreen: background = `COLOR_START;
            gameScreen:  background = `COLOR_GAME;
            endScreen:   background = `COLOR_END;
            default:     background = `COLOR_START;
        endcase
    end

    // buttons only on the menu screens
    always_comb begin
        if (timingIn.blank) begin
            pixel = '0;
        end else if (screen != gameScreen && onButton) begin
            pixel = `COLOR_BUTTON;
        end else begin
            pixel = background;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            paintOut.hsync <= 1'b0;
            paintOut.vsync <= 1'b0;
            // blank until the first real pixel arrives
            paintOut.blank <= 1'b1;
            paintOut.rgb   <= '0;
        end else begin
            paintOut.hsync <= timingIn.hsync;
            paintOut.vsync <= timingIn.vsync;
            paintOut.blank <= timingIn.blank;
            paintOut.rgb   <= pixel;
        end
    end

    // position travels along for the cursor stage
    always_ff @(posedge clk) begin
        paintOut.hcount <= timingIn.hcount;
        paintOut.vcount <= timingIn.vcount;
    end

    blankIsBlack: assert property (
        @(posedge clk) disable iff (rst)
        paintOut.blank |-> (paintOut.rgb == '0)
    ) else $error("colour %h painted during blank", paintOut.rgb);

endmodule

//--- logic/cursorOverlay.sv
`timescale 1ns/1ns

`include "menu_settings.svh"

module cursorOverlay (
    input  logic                clk,
    input  logic                rst,
    input  logic [`COORD_W-1:0] xpos,
    input  logic [`COORD_W-1:0] ypos,
    vgaBus.sink                 paintIn,
    output logic                hsync,
    output logic                vsync,
    output menuPkg::rgbT        rgb
);

    import menuPkg::*;

    logic onCursor;
    rgbT  pixel;

    // square with its top left corner at the mouse position
    assign onCursor = inRect(paintIn.hcount, paintIn.vcount, xpos, ypos,
                             `CURSOR_SIZE - 12'd1, `CURSOR_SIZE - 12'd1);

    always_comb begin
        if (paintIn.blank) begin
            pixel = '0;
        end else if (onCursor) begin
            pixel = `COLOR_CURSOR;
        end else begin
            pixel = paintIn.rgb;
        end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            rgb   <= '0;
        end else begin
            hsync <= paintIn.hsync;
            vsync <= paintIn.vsync;
            rgb   <= pixel;
        end
    end

endmodule

//--- logic/menuTop.sv
`timescale 1ns/1ns

module menuTop (
    input  logic        clk,
    input  logic        rst,
    input  logic        mouseLeft,
    input  logic        mouseRight,
    input  logic [11:0] xpos,
    input  logic [11:0] ypos,
    output logic        hsync,
    output logic        vsync,
    output logic [11:0] rgb,
    output logic [3:0]  screen
);

    import menuPkg::*;

    screenT screenState;

    vgaBus timingBus ();
    vgaBus paintBus ();

    vgaTiming uTiming (
        .clk       (clk),
        .rst       (rst),
        .timingOut (timingBus.src)
    );

    screenFsm uFsm (
        .clk        (clk),
        .rst        (rst),
        .mouseLeft  (mouseLeft),
        .mouseRight (mouseRight),
        .xpos       (xpos),
        .ypos       (ypos),
        .screen     (screenState)
    );

    // two pixel stages, background first then cursor
    menuRenderer uRenderer (
        .clk      (clk),
        .rst      (rst),
        .screen   (screenState),
        .timingIn (timingBus.sink),
        .paintOut (paintBus.src)
    );

    cursorOverlay uCursor (
        .clk     (clk),
        .rst     (rst),
        .xpos    (xpos),
        .ypos    (ypos),
        .paintIn (paintBus.sink),
        .hsync   (hsync),
        .vsync   (vsync),
        .rgb     (rgb)
    );

    assign screen = screenState;

endmodule

//--- tb/menuChecker.sv
`timescale 1ns/1ns

`include "menu_settings.svh"

module menuChecker (
    input  logic        clk,
    input  logic        rst,
    input  logic        mouseLeft,
    input  logic        mouseRight,
    input  logic [11:0] xpos,
    input  logic [11:0] ypos,
    input  logic        hsync,
    input  logic        vsync,
    input  logic [11:0] rgb,
    input  logic [3:0]  screen,
    output int          errorCount,
    output int          changeCount
);

    import menuPkg::*;

    localparam int HActive    = int'(`H_ACTIVE);
    localparam int HTotal     = int'(`H_TOTAL);
    localparam int HSyncStart = int'(`H_ACTIVE + `H_FRONT);
    localparam int HSyncEnd   = int'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam int VActive    = int'(`V_ACTIVE);
    localparam int VTotal     = int'(`V_TOTAL);
    localparam int VSyncStart = int'(`V_ACTIVE + `V_FRONT);
    localparam int VSyncEnd   = int'(`V_ACTIVE + `V_FRONT + `V_SYNC);
    localparam int ButtonX    = int'(`BUTTON_X);
    localparam int ButtonW    = int'(`BUTTON_W);
    localparam int ButtonH    = int'(`BUTTON_H);
    localparam int CursorSize = int'(`CURSOR_SIZE);

    int          hModel;
    int          vModel;
    screenT      screenModel;
    screenT      screenNext;
    // {hsync, vsync, rgb} per pixel
    logic [13:0] predNow;
    logic [13:0] predOne;
    logic [13:0] predTwo;
    int          errors = 0;
    int          changes = 0;

    assign errorCount  = errors;
    assign changeCount = changes;

    function automatic logic inButton(input int x, input int y, input int top);
        return (x >= ButtonX) && (x <= ButtonX + ButtonW) && (y >= top) && (y <= top + ButtonH);
    endfunction

    function automatic logic onAnyButton(input int x, input int y);
        return inButton(x, y, int'(`BUTTON_Y1)) || inButton(x, y, int'(`BUTTON_Y2));
    endfunction

    function automatic screenT nextScreen(input screenT s, input logic left, input logic right,
                                          input int x, input int y);
        screenT n;
        n = s;
        if (s == startScreen && left && onAnyButton(x, y)) begin
            n = gameScreen;
        end else if (s == gameScreen && right) begin
            n = endScreen;
        end else if (s == endScreen && left && inButton(x, y, int'(`BUTTON_Y1))) begin
            n = startScreen;
        end else if (s == endScreen && left && inButton(x, y, int'(`BUTTON_Y2))) begin
            n = gameScreen;
        end
        return n;
    endfunction

    // blank, then cursor, then buttons, then background
    function automatic rgbT pixelColour(input int h, input int v, input int cx, input int cy,
                                        input screenT s);
        rgbT colour;
        if (h >= HActive || v >= VActive) begin
            colour = '0;
        end else if (h >= cx && h <= cx + CursorSize - 1 &&
                     v >= cy && v <= cy + CursorSize - 1) begin
            colour = `COLOR_CURSOR;
        end else if (s != gameScreen && onAnyButton(h, v)) begin
            colour = `COLOR_BUTTON;
        end else if (s == gameScreen) begin
            colour = `COLOR_GAME;
        end else if (s == endScreen) begin
            colour = `COLOR_END;
        end else begin
            colour = `COLOR_START;
        end
        return colour;
    endfunction

    task automatic compareValue(input string name, input logic [11:0] expected,
                                input logic [11:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // model, sampled mid cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            hModel      = 0;
            vModel      = 0;
            screenModel = startScreen;
            predOne     = '0;
            predTwo     = '0;
        end else begin
            compareValue("screen", 12'(screenModel), 12'(screen));
            compareValue("hsync", 12'(predTwo[13]), 12'(hsync));
            compareValue("vsync", 12'(predTwo[12]), 12'(vsync));
            compareValue("rgb", predTwo[11:0], rgb);
            predNow[13]   = (hModel >= HSyncStart) && (hModel < HSyncEnd);
            predNow[12]   = (vModel >= VSyncStart) && (vModel < VSyncEnd);
            predNow[11:0] = pixelColour(hModel, vModel, int'(xpos), int'(ypos), screenModel);
            predTwo = predOne;
            predOne = predNow;
            // inputs seen here are the ones the next edge samples
            screenNext = nextScreen(screenModel, mouseLeft, mouseRight, int'(xpos), int'(ypos));
            if (screenNext != screenModel) begin
                changes++;
            end
            screenModel = screenNext;
            hModel++;
            if (hModel == HTotal) begin
                hModel = 0;
                vModel = (vModel + 1) % VTotal;
            end
        end
    end

endmodule

//--- tb/menuTb.sv
`timescale 1ns/1ns

`include "menu_settings.svh"

module menuTb;

    localparam int Frames         = 4;
    localparam int LineCycles     = int'(`H_TOTAL);
    localparam int FrameCycles    = int'(`H_TOTAL) * int'(`V_TOTAL);
    // four frames of 663168 cycles plus some slack
    localparam int CycleLimit     = 3000000;
    // pointer moves and clicks happen on this line deep in vertical blank
    localparam int MoveLine       = int'(`V_ACTIVE) + 10;
    localparam int ClicksPerFrame = 6;

    logic        clk;
    logic        rst;
    logic        mouseLeft;
    logic        mouseRight;
    logic [11:0] xpos;
    logic [11:0] ypos;
    logic        hsync;
    logic        vsync;
    logic [11:0] rgb;
    logic [3:0]  screen;
    int          errorCount;
    int          changeCount;
    int          now;
    int          cycle = 0;

    menuTop dut (
        .clk        (clk),
        .rst        (rst),
        .mouseLeft  (mouseLeft),
        .mouseRight (mouseRight),
        .xpos       (xpos),
        .ypos       (ypos),
        .hsync      (hsync),
        .vsync      (vsync),
        .rgb        (rgb),
        .screen     (screen)
    );

    menuChecker uChecker (
        .clk         (clk),
        .rst         (rst),
        .mouseLeft   (mouseLeft),
        .mouseRight  (mouseRight),
        .xpos        (xpos),
        .ypos        (ypos),
        .hsync       (hsync),
        .vsync       (vsync),
        .rgb         (rgb),
        .screen      (screen),
        .errorCount  (errorCount),
        .changeCount (changeCount)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == CycleLimit) begin
            $display("run stopped after %0d cycles, the stimulus did not finish", cycle);
            $display("Result: FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // now counts cycles from the first counter value (0,0)
    task automatic stepTo(input int target);
        while (now < target) begin
            @(posedge clk);
            #2;
            now++;
        end
    endtask

    // half of the positions land inside a button
    task automatic movePointer();
        int pick;
        pick = $urandom_range(3, 0);
        if (pick == 0) begin
            xpos = `BUTTON_X + 12'($urandom_range(int'(`BUTTON_W), 0));
            ypos = `BUTTON_Y1 + 12'($urandom_range(int'(`BUTTON_H), 0));
        end else if (pick == 1) begin
            xpos = `BUTTON_X + 12'($urandom_range(int'(`BUTTON_W), 0));
            ypos = `BUTTON_Y2 + 12'($urandom_range(int'(`BUTTON_H), 0));
        end else begin
            xpos = 12'($urandom_range(int'(`H_ACTIVE) - 1, 0));
            ypos = 12'($urandom_range(int'(`V_ACTIVE) - 1, 0));
        end
    endtask

    // left, right or nothing for one cycle
    task automatic pulseClick();
        int kind;
        kind = $urandom_range(2, 0);
        mouseLeft  = (kind == 0);
        mouseRight = (kind == 1);
        stepTo(now + 1);
        mouseLeft  = 1'b0;
        mouseRight = 1'b0;
        stepTo(now + 3);
    endtask

    initial begin
        void'($urandom(24812));
        clk        = 1'b0;
        rst        = 1'b1;
        mouseLeft  = 1'b0;
        mouseRight = 1'b0;
        // cursor starts on the first pixel of the frame
        xpos       = 12'd0;
        ypos       = 12'd0;
        now        = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int f = 0; f < Frames; f++) begin
            stepTo(f * FrameCycles + MoveLine * LineCycles);
            movePointer();
            stepTo(now + 4);
            repeat (ClicksPerFrame) pulseClick();
        end
        // last frame plus the two pipeline stages
        stepTo(Frames * FrameCycles + 2);
        $display("%0d screen changes seen, %0d errors", changeCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
logic/menuPkg.sv
logic/vgaBus.sv
logic/vgaTiming.sv
logic/screenFsm.sv
logic/menuRenderer.sv
logic/cursorOverlay.sv
logic/menuTop.sv
tb/menuChecker.sv
tb/menuTb.sv

//--- run.sh
#!/bin/sh
# build and run the menu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module menuTb -f vlog.f -Mdir obj_dir -o menuSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/menuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation run passed"
    exit 0
fi

echo "simulation run failed, see sim.log"
exit 1
